//--- src.f
+incdir+.
rename_types_pkg.sv
rename_if_pkg.sv
rename_table.sv
free_list.sv
rename_unit.sv
rename_unit_sva.sv
tb_rename_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the rename stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_rename_unit \
    --Mdir obj_dir -o sim_rename_unit
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/sim_rename_unit
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "Simulation ended with status $run_status"
    exit $run_status
fi

exit 0

//--- tb_rename_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage testbench, random
// stream against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module tb_rename_unit
    import rename_types_pkg::*, rename_if_pkg::*;
();

    logic        clk;
    logic        rstn;
    logic        req_valid;
    rename_req_t req;
    logic        req_ready;
    logic        rsp_valid;
    rename_rsp_t rsp;
    commit_t     commit;
    recover_t    recover;

    // Reference model state
    int      spec_map [`RN_NUM_ISA_REGS];                        // Working map
    int      commit_map [`RN_NUM_ISA_REGS];
    int      cp_map [`RN_NUM_CHECKPOINTS][`RN_NUM_ISA_REGS];     // Map before each branch
    int      cp_fl_head [`RN_NUM_CHECKPOINTS];                   // Free head before each branch
    int      cp_age [`RN_NUM_CHECKPOINTS];                       // Writers older than the branch
    int      fl [`RN_FREE_DEPTH];
    int      fl_head;
    int      fl_tail;
    int      fl_commit;
    int      n_com;                                              // Writers committed so far
    int      cp_head;
    int      cp_tail;
    int      cp_cnt;
    commit_t inflight [$];                                       // Uncommitted writers, oldest first

    rename_unit uut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .commit_i    (commit),
        .recover_i   (recover)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic rename_req_t random_req();
        rename_req_t rq;
        rq.src1          = reg_t'($urandom % 32);
        rq.src2          = reg_t'($urandom % 32);
        rq.dst           = reg_t'($urandom % 32);
        rq.write_dst     = ($urandom % 100) < 55;
        rq.do_checkpoint = ($urandom % 100) < 20; // Often enough to fill the ring
        return rq;
    endfunction

    // One handshake cycle, starts and ends on a falling edge
    task automatic run_cycle(input rename_req_t rq, input logic do_commit, input recover_t rc);
        commit_t cm;
        commit_t entry;
        logic    writer;
        logic    recovering;
        logic    exp_ready;
        int      exp_src1;
        int      exp_src2;
        int      exp_old;
        int      exp_new;
        int      exp_cp;
        int      waited;
        cm = '0;
        if (do_commit && inflight.size() > 0) begin
            cm = inflight[0]; // In-order retire of the oldest writer
        end
        writer     = rq.write_dst && (rq.dst != 0);
        recovering = rc.branch_recover || rc.exception_recover;
        exp_ready  = !recovering && !(writer && fl_head == fl_tail)
                     && !(rq.do_checkpoint && cp_cnt == `RN_NUM_CHECKPOINTS - 1);
        req_valid = 1'b1;
        req       = rq;
        commit    = cm;
        recover   = rc;
        #1;
        expect_equal("req_ready_o", req_ready, exp_ready);
        exp_src1 = (rq.src1 == 0) ? 0 : spec_map[rq.src1]; // x0 pinned to p0
        exp_src2 = (rq.src2 == 0) ? 0 : spec_map[rq.src2];
        exp_old  = (rq.dst == 0) ? 0 : spec_map[rq.dst];
        exp_new  = writer ? fl[fl_head % `RN_FREE_DEPTH] : 0;
        exp_cp   = cp_head;
        @(posedge clk);
        if (cm.valid) begin
            commit_map[cm.dst] = cm.new_dst;
            fl[fl_tail % `RN_FREE_DEPTH] = cm.old_dst; // Old mapping back at the tail
            fl_tail++;
            fl_commit++;
            n_com++;
            void'(inflight.pop_front());
        end
        if (rc.exception_recover) begin
            for (int j = 0; j < `RN_NUM_ISA_REGS; j++) spec_map[j] = commit_map[j];
            fl_head = fl_commit;
            cp_head = 0;
            cp_tail = 0;
            cp_cnt  = 0;
            inflight.delete();
        end else if (rc.branch_recover) begin
            for (int j = 0; j < `RN_NUM_ISA_REGS; j++) spec_map[j] = cp_map[rc.recover_cp][j];
            fl_head = cp_fl_head[rc.recover_cp];
            while (inflight.size() > cp_age[rc.recover_cp] - n_com) begin
                void'(inflight.pop_back()); // Younger than the branch
            end
            cp_head = rc.recover_cp;
            cp_cnt  = (cp_head - cp_tail + `RN_NUM_CHECKPOINTS) % `RN_NUM_CHECKPOINTS;
        end else begin
            if (rc.delete_cp) begin
                cp_tail = (cp_tail + 1) % `RN_NUM_CHECKPOINTS;
                cp_cnt--;
            end
            if (exp_ready && rq.do_checkpoint) begin
                for (int j = 0; j < `RN_NUM_ISA_REGS; j++) cp_map[cp_head][j] = spec_map[j];
                cp_fl_head[cp_head] = fl_head;
                cp_age[cp_head]     = n_com + inflight.size();
                cp_head = (cp_head + 1) % `RN_NUM_CHECKPOINTS;
                cp_cnt++;
            end
            if (exp_ready && writer) begin
                spec_map[rq.dst] = exp_new;
                fl_head++;
                entry           = '0;
                entry.valid     = 1'b1;
                entry.write_dst = 1'b1;
                entry.dst       = rq.dst;
                entry.new_dst   = phreg_t'(exp_new);
                entry.old_dst   = phreg_t'(exp_old);
                inflight.push_back(entry);
            end
        end
        @(negedge clk);
        for (waited = 1; exp_ready && !rsp_valid && waited < 4; waited++) @(negedge clk);
        if (exp_ready) begin
            if (!rsp_valid) begin
                abort_run("timeout waiting for rsp_valid_o after an accepted request");
            end
            expect_equal("rsp latency", waited, 1);
            expect_equal("rsp_o.src1", rsp.src1, exp_src1);
            expect_equal("rsp_o.src2", rsp.src2, exp_src2);
            expect_equal("rsp_o.old_dst", rsp.old_dst, exp_old);
            expect_equal("rsp_o.new_dst", rsp.new_dst, exp_new);
            expect_equal("rsp_o.checkpoint", rsp.checkpoint, exp_cp);
        end else begin
            expect_equal("rsp_valid_o", rsp_valid, 0); // Nothing taken while not ready
        end
    endtask

    initial begin
        rename_req_t rq;
        recover_t    rc;
        logic        do_commit;
        int          roll;
        void'($urandom(15));
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        commit    = '0;
        recover   = '0;
        for (int j = 0; j < `RN_NUM_ISA_REGS; j++) begin
            spec_map[j]   = j; // Identity after reset
            commit_map[j] = j;
        end
        for (int i = 0; i < `RN_FREE_DEPTH; i++) fl[i] = `RN_NUM_ISA_REGS + i;
        fl_head   = 0;
        fl_tail   = `RN_FREE_DEPTH;
        fl_commit = 0;
        n_com     = 0;
        cp_head   = 0;
        cp_tail   = 0;
        cp_cnt    = 0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        // Identity lookups, then first allocations in order
        for (int r = 0; r < `RN_NUM_ISA_REGS; r++) begin
            rq      = '0;
            rq.src1 = reg_t'(r);
            rq.src2 = reg_t'(31 - r);
            run_cycle(rq, 1'b0, '0);
            expect_equal("rsp_o.src1", rsp.src1, r);
        end
        for (int i = 0; i < 4; i++) begin
            rq           = '0;
            rq.dst       = reg_t'(i + 1);
            rq.write_dst = 1'b1;
            run_cycle(rq, 1'b0, '0);
            expect_equal("rsp_o.new_dst", rsp.new_dst, `RN_NUM_ISA_REGS + i);
        end

        // Branch phase first, commits with exceptions in the second half
        for (int i = 0; i < 1200; i++) begin
            rq        = random_req();
            rc        = '0;
            do_commit = (i >= 600) && (($urandom % 100) < 40);
            roll      = $urandom % 100;
            if (roll < 7 && cp_cnt > 0 && i < 600) begin
                rc.branch_recover = 1'b1;
                rc.recover_cp     = checkpoint_ptr_t'(cp_tail + $urandom % cp_cnt);
            end else if (roll < 10) begin
                rc.exception_recover = 1'b1;
            end else if (roll < 15 && cp_cnt > 0) begin
                rc.delete_cp = 1'b1;
            end
            run_cycle(rq, do_commit, rc);
        end

        // Clean state, then fill the checkpoint ring
        rc                   = '0;
        rc.exception_recover = 1'b1;
        run_cycle('0, 1'b0, rc);
        for (int n = 0; n < `RN_NUM_CHECKPOINTS; n++) begin
            rq               = '0;
            rq.src1          = reg_t'(n + 1);
            rq.do_checkpoint = 1'b1;
            run_cycle(rq, 1'b0, '0); // Last one finds 3 live checkpoints
        end
        expect_equal("req_ready_o", req_ready, 0);

        // Drain the free list, one writer more than it holds
        for (int n = 0; n <= `RN_FREE_DEPTH; n++) begin
            rq               = random_req();
            rq.dst           = reg_t'(1 + n % 31);
            rq.write_dst     = 1'b1;
            rq.do_checkpoint = 1'b0;
            run_cycle(rq, 1'b0, '0);
        end
        expect_equal("req_ready_o", req_ready, 0);

        req_valid = 1'b0;
        req       = '0;
        commit    = '0;
        recover   = '0;
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rename_unit_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and free list checks
// bound into the rename top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module rename_unit_sva
    import rename_if_pkg::*;
(
    input wire      clk_i,
    input wire      rstn_i,
    input logic     req_valid_i,
    input logic     req_ready_i,
    input logic     rsp_valid_i,
    input recover_t recover_i,
    input logic     alloc_i,    // Free list pop
    input logic     fl_empty_i
);

    logic accept;

    assign accept = req_valid_i & req_ready_i;

    // Response one cycle after accept, and only then
    rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |=> rsp_valid_i) else $error("rsp_valid_o missing after accept");
    rsp_only_on_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !accept |=> !rsp_valid_i) else $error("rsp_valid_o without accept");

    ready_low_in_recovery: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (recover_i.branch_recover || recover_i.exception_recover) |-> !req_ready_i)
        else $error("req_ready_o high during recovery");

    no_alloc_when_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        alloc_i |-> !fl_empty_i) else $error("free list popped while empty");

endmodule

bind rename_unit rename_unit_sva u_rename_unit_sva (
    .clk_i,
    .rstn_i,
    .req_valid_i,
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .recover_i,
    .alloc_i     (alloc),
    .fl_empty_i  (fl_empty)
);

`default_nettype wire

//--- rename_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage top, handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module rename_unit
    import rename_types_pkg::*, rename_if_pkg::*;
(
    input  wire         clk_i,
    input  wire         rstn_i,
    input  logic        req_valid_i,
    input  rename_req_t req_i,
    output logic        req_ready_o,
    output logic        rsp_valid_o,
    output rename_rsp_t rsp_o,
    input  commit_t     commit_i,
    input  recover_t    recover_i
);

    rename_req_t     tbl_req;   // Request as seen by the table
    phreg_t          free_reg;
    phreg_t          new_dst_q;
    phreg_t          src1;
    phreg_t          src2;
    phreg_t          old_dst;
    checkpoint_ptr_t cp_label;
    logic            fl_empty;
    logic            cp_full;
    logic            recovering;
    logic            needs_reg;
    logic            accept;
    logic            alloc;

    assign recovering = recover_i.branch_recover | recover_i.exception_recover;
    assign needs_reg  = req_i.write_dst & (req_i.dst != '0);

    // Back-pressure on empty free list, full ring or recovery
    assign req_ready_o = ~recovering & ~(needs_reg & fl_empty) & ~(req_i.do_checkpoint & cp_full);
    assign accept      = req_valid_i & req_ready_o;
    assign alloc       = accept & needs_reg;
    assign tbl_req     = accept ? req_i : '0; // Idle cycles look up x0

    rename_table u_rename_table (
        .clk_i,
        .rstn_i,
        .req_i        (tbl_req),
        .alloc_i      (alloc),
        .new_dst_i    (free_reg),
        .commit_i,
        .recover_i,
        .src1_o       (src1),
        .src2_o       (src2),
        .old_dst_o    (old_dst),
        .checkpoint_o (cp_label),
        .cp_full_o    (cp_full)
    );

    free_list u_free_list (
        .clk_i,
        .rstn_i,
        .alloc_i      (alloc),
        .checkpoint_i (tbl_req.do_checkpoint),
        .recover_i,
        .commit_i,
        .free_reg_o   (free_reg),
        .empty_o      (fl_empty)
    );

    // Lines up with the registered table lookups
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_o <= 1'b0;
            new_dst_q   <= '0;
        end else begin
            rsp_valid_o <= accept;
            new_dst_q   <= alloc ? free_reg : '0;
        end
    end

    assign rsp_o = '{src1: src1, src2: src2, new_dst: new_dst_q, old_dst: old_dst,
                     checkpoint: cp_label};

endmodule

`default_nettype wire

//--- free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular free list with saved
// heads and a commit pointer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list
    import rename_types_pkg::*, rename_if_pkg::*;
(
    input  wire      clk_i,
    input  wire      rstn_i,
    input  logic     alloc_i,      // Pop the head entry
    input  logic     checkpoint_i, // Save the head for a new branch
    input  recover_t recover_i,
    input  commit_t  commit_i,
    output phreg_t   free_reg_o,   // Next register to hand out
    output logic     empty_o
);

    localparam int IDX_W = $clog2(`RN_FREE_DEPTH);

    phreg_t          fifo_q [`RN_FREE_DEPTH];
    free_ptr_t       saved_head_q [`RN_NUM_CHECKPOINTS]; // Head at each checkpoint
    free_ptr_t       head_q;     // Allocation side
    free_ptr_t       tail_q;     // Release side
    free_ptr_t       commit_q;   // Head as seen by committed state
    free_ptr_t       commit_nxt;
    checkpoint_ptr_t cp_head_q;  // Tracks the map table's working copy
    logic            release_en;

    // x0 never allocated, so nothing to free either
    assign release_en = commit_i.valid & commit_i.write_dst & (commit_i.dst != '0);

    // Each committed writer consumed one entry
    assign commit_nxt = commit_q + free_ptr_t'(release_en);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                fifo_q[i] <= phreg_t'(`RN_NUM_ISA_REGS + i); // 32..63 in order
            end
            head_q    <= '0;
            tail_q    <= free_ptr_t'(`RN_FREE_DEPTH); // Full, wrap bit set
            commit_q  <= '0;
            cp_head_q <= '0;
        end else begin
            // Old mapping returns at the tail
            if (release_en) begin
                fifo_q[tail_q[IDX_W-1:0]] <= commit_i.old_dst;
                tail_q <= tail_q + 1'b1;
            end
            commit_q <= commit_nxt;

            if (recover_i.exception_recover) begin
                head_q    <= commit_nxt; // Speculative allocations come back
                cp_head_q <= '0;
            end else if (recover_i.branch_recover) begin
                head_q    <= saved_head_q[recover_i.recover_cp];
                cp_head_q <= recover_i.recover_cp;
            end else begin
                if (alloc_i) begin
                    head_q <= head_q + 1'b1;
                end
                if (checkpoint_i) begin
                    cp_head_q <= cp_head_q + 1'b1;
                end
            end
        end
    end

    // Head before this instruction's allocation, same slot as the map copy
    always_ff @(posedge clk_i) begin
        if (checkpoint_i) begin
            saved_head_q[cp_head_q] <= head_q;
        end
    end

    assign free_reg_o = fifo_q[head_q[IDX_W-1:0]];
    assign empty_o    = (head_q == tail_q); // Same index and same wrap

endmodule

`default_nettype wire

//--- rename_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Speculative map table with a
// checkpoint ring, commit table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_table
    import rename_types_pkg::*, rename_if_pkg::*;
(
    input  wire             clk_i,
    input  wire             rstn_i,
    input  rename_req_t     req_i,        // Accepted request, zero when idle
    input  logic            alloc_i,      // Write new_dst_i into the map
    input  phreg_t          new_dst_i,    // Head of the free list
    input  commit_t         commit_i,
    input  recover_t        recover_i,
    output phreg_t          src1_o,
    output phreg_t          src2_o,
    output phreg_t          old_dst_o,
    output checkpoint_ptr_t checkpoint_o, // Label of the copy saved for a branch
    output logic            cp_full_o     // No free copy left
);

    // Map ring, copy head_q is the working map
    phreg_t map_q [`RN_NUM_ISA_REGS][`RN_NUM_CHECKPOINTS];
    phreg_t commit_tbl_q [`RN_NUM_ISA_REGS];

    checkpoint_ptr_t head_q;    // Working copy
    checkpoint_ptr_t tail_q;    // Oldest live checkpoint
    checkpoint_cnt_t cp_cnt_q;  // Live checkpoints
    checkpoint_ptr_t head_inc;
    checkpoint_ptr_t tail_nxt;
    checkpoint_ptr_t wr_cp;     // Copy that takes the new mapping
    logic            cp_en;
    logic            commit_en;

    assign cp_en     = req_i.do_checkpoint; // Top only passes it when ready
    assign commit_en = commit_i.valid & commit_i.write_dst & (commit_i.dst != '0);
    assign head_inc  = head_q + 1'b1;
    assign tail_nxt  = tail_q + checkpoint_ptr_t'(recover_i.delete_cp);

    // Snapshot holds the map before this instruction, so its write lands in the new copy
    assign wr_cp = cp_en ? head_inc : head_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int j = 0; j < `RN_NUM_ISA_REGS; j++) begin
                for (int c = 0; c < `RN_NUM_CHECKPOINTS; c++) begin
                    map_q[j][c] <= phreg_t'(j); // Identity map
                end
                commit_tbl_q[j] <= phreg_t'(j);
            end
            head_q       <= '0;
            tail_q       <= '0;
            cp_cnt_q     <= '0;
            src1_o       <= '0;
            src2_o       <= '0;
            old_dst_o    <= '0;
            checkpoint_o <= '0;
        end else begin
            // Registered lookups from the working copy, before any write
            src1_o       <= (req_i.src1 == '0) ? '0 : map_q[req_i.src1][head_q];
            src2_o       <= (req_i.src2 == '0) ? '0 : map_q[req_i.src2][head_q];
            old_dst_o    <= (req_i.dst == '0) ? '0 : map_q[req_i.dst][head_q];
            checkpoint_o <= head_q;

            if (commit_en) begin
                commit_tbl_q[commit_i.dst] <= commit_i.new_dst;
            end

            if (recover_i.exception_recover) begin
                // Committed map into copy 0, same-cycle commit included
                for (int j = 0; j < `RN_NUM_ISA_REGS; j++) begin
                    if (commit_en && (commit_i.dst == reg_t'(j))) begin
                        map_q[j][0] <= commit_i.new_dst;
                    end else begin
                        map_q[j][0] <= commit_tbl_q[j];
                    end
                end
                head_q   <= '0;
                tail_q   <= '0;
                cp_cnt_q <= '0;
            end else if (recover_i.branch_recover) begin
                // Saved copy becomes the working map, younger ones are dropped
                head_q   <= recover_i.recover_cp;
                tail_q   <= tail_nxt;
                cp_cnt_q <= checkpoint_cnt_t'(checkpoint_ptr_t'(recover_i.recover_cp - tail_nxt));
            end else begin
                tail_q   <= tail_nxt;
                cp_cnt_q <= cp_cnt_q + checkpoint_cnt_t'(cp_en)
                            - checkpoint_cnt_t'(recover_i.delete_cp);
                if (cp_en) begin
                    for (int j = 0; j < `RN_NUM_ISA_REGS; j++) begin
                        map_q[j][head_inc] <= map_q[j][head_q];
                    end
                    head_q <= head_inc;
                end
                // After the copy loop so the new mapping wins
                if (alloc_i) begin
                    map_q[req_i.dst][wr_cp] <= new_dst_i;
                end
            end
        end
    end

    // One copy stays in use as the working map
    assign cp_full_o = (cp_cnt_q == checkpoint_cnt_t'(`RN_NUM_CHECKPOINTS - 1));

endmodule

`default_nettype wire

//--- rename_if_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Structs exchanged with the
// neighbors of the rename stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rename_if_pkg;
    import rename_types_pkg::*;

    // Instruction entering rename, from decode
    typedef struct packed {
        reg_t src1;          // First source
        reg_t src2;          // Second source
        reg_t dst;           // Destination
        logic write_dst;     // Instruction writes dst
        logic do_checkpoint; // Branch, snapshot the map
    } rename_req_t;

    // Renamed instruction, to dispatch
    typedef struct packed {
        phreg_t          src1;       // Physical source 1
        phreg_t          src2;       // Physical source 2
        phreg_t          new_dst;    // Freshly allocated register, 0 if none
        phreg_t          old_dst;    // Previous mapping of dst, freed at commit
        checkpoint_ptr_t checkpoint; // Label to recover this branch
    } rename_rsp_t;

    // Retiring instruction, from the ROB
    typedef struct packed {
        logic   valid;
        logic   write_dst;
        reg_t   dst;
        phreg_t new_dst; // Enters the commit table
        phreg_t old_dst; // Goes back to the free list
    } commit_t;

    // Recovery control from branch unit and ROB
    typedef struct packed {
        logic            branch_recover;    // Mispredict, roll back to recover_cp
        logic            exception_recover; // Restore committed state
        checkpoint_ptr_t recover_cp;
        logic            delete_cp;         // Oldest branch resolved correctly
    } recover_t;

endpackage

`default_nettype wire

//--- rename_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Index and pointer vector types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rename_defines.svh"

package rename_types_pkg;

    // Architectural register index, x0..x31
    typedef logic [$clog2(`RN_NUM_ISA_REGS)-1:0] reg_t;

    // Physical register index
    typedef logic [$clog2(`RN_NUM_PHYS_REGS)-1:0] phreg_t;

    // Label of a map copy in the checkpoint ring
    typedef logic [$clog2(`RN_NUM_CHECKPOINTS)-1:0] checkpoint_ptr_t;

    // Live checkpoint count, one bit wider than the label
    typedef logic [$clog2(`RN_NUM_CHECKPOINTS):0] checkpoint_cnt_t;

    // Free list pointer, MSB is the wrap bit
    typedef logic [$clog2(`RN_FREE_DEPTH):0] free_ptr_t;

endpackage

`default_nettype wire

//--- rename_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Size macros of the rename stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural registers, fixed by the RV32 ISA
`define RN_NUM_ISA_REGS 32

// Physical register file of the core
`define RN_NUM_PHYS_REGS 64

// Map copies in the checkpoint ring
// One copy is always the working map, so 3 branches can be in flight
`define RN_NUM_CHECKPOINTS 4

// Free list depth
`define RN_FREE_DEPTH 32 // Phys minus arch registers

`endif
